// ==== dac_pkg.sv ====
/* Stereo DAC shared definitions
   Sample width, stereo sample word and sequencer task codes */

package dac_pkg;

    // ------------------------------------------------------------
    // Sample format
    // ------------------------------------------------------------

    localparam int SAMPLE_W = 18;

    // Left channel in the upper half of the word
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } stereo_sample_t;

    // ------------------------------------------------------------
    // Sequencer program
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        TASK_WAIT_IN,
        TASK_WAIT_DONE,
        TASK_SEND,
        TASK_JUMP
    } seq_task_t;

endpackage

// ==== sample_fifo.sv ====
/* Stereo sample FIFO
   Circular buffer with fill count, registered read data, full and empty flags */

`timescale 1ns/1ps

module sample_fifo #(
    parameter int depth = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr,
    input  dac_pkg::stereo_sample_t wr_data,
    input  logic                    rd,
    output dac_pkg::stereo_sample_t rd_data,
    output logic                    empty,
    output logic                    full
);
    import dac_pkg::*;

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    stereo_sample_t   mem [depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(depth - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(depth));

    // A read frees a slot for a write in the same cycle
    assign do_rd = rd && !empty;
    assign do_wr = wr && (!full || do_rd);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr];
    end

    // No back-pressure upstream, so a lost sample is a scheduling bug
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr && full |-> rd)
        else $error("sample_fifo: write while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd |-> !empty)
        else $error("sample_fifo: read while empty");

endmodule

// ==== interp_2x.sv ====
/* Linear 2x interpolator for stereo samples
   Emits the midpoint of the previous and new input, then the new input */

`timescale 1ns/1ps

module interp_2x (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_in_rdy,
    input  dac_pkg::stereo_sample_t sample_in,
    output logic                    sample_out_rdy,
    output dac_pkg::stereo_sample_t sample_out,
    output logic                    done
);
    import dac_pkg::*;

    stereo_sample_t prev;
    stereo_sample_t mid;
    logic [1:0]     phase;

    // Floor of (a + b) / 2 with one guard bit
    function automatic logic signed [SAMPLE_W-1:0] half_sum(
        input logic signed [SAMPLE_W-1:0] a,
        input logic signed [SAMPLE_W-1:0] b
    );
        logic [SAMPLE_W:0] sum;
        sum = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b};
        return sum[SAMPLE_W:1];
    endfunction

    assign mid.left  = half_sum(prev.left, sample_in.left);
    assign mid.right = half_sum(prev.right, sample_in.right);

    // ------------------------------------------------------------
    // Phase sequence
    // ------------------------------------------------------------
    // 1: midpoint out, 2: idle, 3: new sample out, then done

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase          <= 2'd0;
            sample_out_rdy <= 1'b0;
            done           <= 1'b0;
            prev           <= '0;
        end else begin
            sample_out_rdy <= sample_in_rdy || (phase == 2'd2);
            done           <= (phase == 2'd3);
            if (sample_in_rdy) begin
                prev  <= sample_in;
                phase <= 2'd1;
            end else if (phase != 2'd0) begin
                phase <= phase + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_in_rdy)
            sample_out <= mid;
        else if (phase == 2'd2)
            sample_out <= prev;
    end

endmodule

// ==== dac_sequencer.sv ====
/* Program-counter sequencer for the interpolation chain
   Waits for input and stage completion, then feeds the second stage */

`timescale 1ns/1ps

module dac_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic sample_in_rdy,
    input  logic done,
    output logic send
);
    import dac_pkg::*;

    localparam int PC_W = 3;

    logic [PC_W-1:0] pc;
    seq_task_t       cur_task;

    // ------------------------------------------------------------
    // Task table
    // ------------------------------------------------------------

    always_comb begin
        case (pc)
            3'd0:    cur_task = TASK_WAIT_IN;
            // Stage one finishes its pair
            3'd1:    cur_task = TASK_WAIT_DONE;
            3'd2:    cur_task = TASK_SEND;
            // Stage two works on the midpoint
            3'd3:    cur_task = TASK_WAIT_DONE;
            3'd4:    cur_task = TASK_SEND;
            3'd5:    cur_task = TASK_WAIT_DONE;
            default: cur_task = TASK_JUMP;
        endcase
    end

    assign send = (cur_task == TASK_SEND);

    // ------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            case (cur_task)
                TASK_JUMP:      pc <= '0;
                TASK_WAIT_IN:   if (sample_in_rdy) pc <= pc + PC_W'(1);
                TASK_WAIT_DONE: if (done) pc <= pc + PC_W'(1);
                default:        pc <= pc + PC_W'(1);
            endcase
        end
    end

    // Each SEND step pops exactly one sample from the mid FIFO
    a_send_single: assert property (@(posedge clk) disable iff (reset)
        (cur_task == TASK_SEND) |=> !send)
        else $error("dac_sequencer: send held for two cycles");

endmodule

// ==== rate_timer.sv ====
/* Output sample rate timer
   Pulls one sample per period from the output FIFO, flags underrun when empty */

`timescale 1ns/1ps

module rate_timer #(
    parameter int clk_div = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic fifo_empty,
    output logic rd_out,
    output logic underrun
);

    localparam int CNT_W = (clk_div > 1) ? $clog2(clk_div) : 1;

    logic [CNT_W-1:0] cnt;
    logic             tick;

    assign tick = (cnt == CNT_W'(clk_div - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt      <= '0;
            rd_out   <= 1'b0;
            underrun <= 1'b0;
        end else begin
            cnt      <= tick ? '0 : cnt + CNT_W'(1);
            // Skip the read when nothing is waiting
            rd_out   <= tick && !fifo_empty;
            underrun <= tick && fifo_empty;
        end
    end

endmodule

// ==== sigma_delta_mod.sv ====
/* Stereo second-order sigma-delta modulator
   One output bit per channel, updated on each sample load */

`timescale 1ns/1ps

module sigma_delta_mod (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load,
    input  dac_pkg::stereo_sample_t sample,
    output logic                    dout_l,
    output logic                    dout_r
);
    import dac_pkg::*;

    // Headroom for integrator growth near full scale
    localparam int ACC_W = SAMPLE_W + 12;
    localparam logic signed [ACC_W-1:0] FULL_SCALE = ACC_W'(2 ** (SAMPLE_W - 1));

    logic signed [ACC_W-1:0] x_ext     [2];
    logic signed [ACC_W-1:0] fb        [2];
    logic signed [ACC_W-1:0] int1      [2];
    logic signed [ACC_W-1:0] int2      [2];
    logic signed [ACC_W-1:0] int1_next [2];
    logic signed [ACC_W-1:0] int2_next [2];
    logic [1:0]              bits;

    // Channel 0 is left, channel 1 is right
    assign x_ext[0] = {{(ACC_W - SAMPLE_W){sample.left[SAMPLE_W-1]}}, sample.left};
    assign x_ext[1] = {{(ACC_W - SAMPLE_W){sample.right[SAMPLE_W-1]}}, sample.right};

    // ------------------------------------------------------------
    // Loop filter
    // ------------------------------------------------------------

    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            fb[ch]        = bits[ch] ? FULL_SCALE : -FULL_SCALE;
            int1_next[ch] = int1[ch] + x_ext[ch] - fb[ch];
            int2_next[ch] = int2[ch] + int1_next[ch] - fb[ch];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int ch = 0; ch < 2; ch++) begin
                int1[ch] <= '0;
                int2[ch] <= '0;
            end
            bits <= 2'b00;
        end else if (load) begin
            for (int ch = 0; ch < 2; ch++) begin
                int1[ch] <= int1_next[ch];
                int2[ch] <= int2_next[ch];
                // 1 means positive
                bits[ch] <= ~int2_next[ch][ACC_W-1];
            end
        end
    end

    assign dout_l = bits[0];
    assign dout_r = bits[1];

endmodule

// ==== stereo_dac_output.sv ====
/* Stereo oversampling DAC back end
   Two 2x interpolators, FIFOs, sequencer, rate timer and sigma-delta modulator */

`timescale 1ns/1ps

module stereo_dac_output #(
    parameter int CLK_DIV   = 8,
    parameter int MID_DEPTH = 2,
    parameter int OUT_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_in_rdy,
    input  dac_pkg::stereo_sample_t sample_in,
    output logic                    dac_out_l,
    output logic                    dac_out_r,
    output logic                    underrun
);
    import dac_pkg::*;

    stereo_sample_t s1_out;
    stereo_sample_t mid_data;
    stereo_sample_t s2_out;
    stereo_sample_t out_data;
    logic           s1_rdy;
    logic           s1_done;
    logic           s2_rdy;
    logic           s2_done;
    logic           stage_done;
    logic           send;
    logic           mid_rd_q;
    logic           out_rd;
    logic           out_rd_q;
    logic           out_empty;

    assign stage_done = s1_done | s2_done;

    // ------------------------------------------------------------
    // Interpolation chain
    // ------------------------------------------------------------

    interp_2x i_stage1 (
        .clk, .reset,
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .sample_out_rdy (s1_rdy),
        .sample_out     (s1_out),
        .done           (s1_done)
    );

    sample_fifo #(.depth(MID_DEPTH)) i_mid_fifo (
        .clk, .reset,
        .wr (s1_rdy), .wr_data (s1_out),
        .rd (send),   .rd_data (mid_data),
        .empty (),    .full ()
    );

    dac_sequencer i_seq (
        .clk, .reset,
        .sample_in_rdy (sample_in_rdy),
        .done          (stage_done),
        .send          (send)
    );

    // Read data lands one cycle after the strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mid_rd_q <= 1'b0;
            out_rd_q <= 1'b0;
        end else begin
            mid_rd_q <= send;
            out_rd_q <= out_rd;
        end
    end

    interp_2x i_stage2 (
        .clk, .reset,
        .sample_in_rdy  (mid_rd_q),
        .sample_in      (mid_data),
        .sample_out_rdy (s2_rdy),
        .sample_out     (s2_out),
        .done           (s2_done)
    );

    sample_fifo #(.depth(OUT_DEPTH)) i_out_fifo (
        .clk, .reset,
        .wr (s2_rdy), .wr_data (s2_out),
        .rd (out_rd), .rd_data (out_data),
        .empty (out_empty), .full ()
    );

    // ------------------------------------------------------------
    // Output rate and modulator
    // ------------------------------------------------------------

    rate_timer #(.clk_div(CLK_DIV)) i_timer (
        .clk, .reset,
        .fifo_empty (out_empty),
        .rd_out     (out_rd),
        .underrun   (underrun)
    );

    sigma_delta_mod i_mod (
        .clk, .reset,
        .load   (out_rd_q),
        .sample (out_data),
        .dout_l (dac_out_l),
        .dout_r (dac_out_r)
    );

endmodule

// ==== tb_stereo_dac_output.sv ====
/* Testbench for the stereo DAC back end
   Table of constant stereo inputs, checks output bit density and underrun */

`timescale 1ns/1ps

module tb_stereo_dac_output;
    import dac_pkg::*;

    localparam int CLK_DIV    = 8;
    // One input gives four output samples, so this keeps the output FIFO level steady
    localparam int IN_PERIOD  = 4 * CLK_DIV;
    localparam int SETTLE     = 32;
    localparam int DRAIN_WAIT = 40;
    localparam int IDLE_WAIT  = 2 * CLK_DIV + 2;
    localparam int HALF_SCALE = 1 << (SAMPLE_W - 1);
    localparam int N_ROWS     = 5;

    // ------------------------------------------------------------
    // Stimulus table of left value, right value and strobes per run
    // ------------------------------------------------------------

    localparam int ROW_LEFT    [N_ROWS] = '{0,  65536, -65536,  126976, -126976};
    localparam int ROW_RIGHT   [N_ROWS] = '{0, -65536,  65536, -126976,  126976};
    localparam int ROW_STROBES [N_ROWS] = '{320, 320, 320, 320, 320};

    logic           clk;
    logic           reset;
    logic           sample_in_rdy;
    stereo_sample_t sample_in;
    logic           dac_out_l;
    logic           dac_out_r;
    logic           underrun;

    stereo_dac_output #(.CLK_DIV(CLK_DIV)) i_dut (
        .clk           (clk),
        .reset         (reset),
        .sample_in_rdy (sample_in_rdy),
        .sample_in     (sample_in),
        .dac_out_l     (dac_out_l),
        .dac_out_r     (dac_out_r),
        .underrun      (underrun)
    );

    always #5 clk = ~clk;

    task automatic report_and_stop(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expect_low(input logic value, input string name);
        assert (value === 1'b0)
            else report_and_stop($sformatf("MISMATCH t=%0t %s got=%b expected=0",
                                           $time, name, value));
    endtask

    // Modulator ones density is (x + 2^17) / 2^18
    task automatic check_density(input string name, input int ones, input int cycles,
                                 input int value);
        longint expected;
        longint diff;
        longint tol;
        expected = (longint'(value) + HALF_SCALE) * cycles / (2 * HALF_SCALE);
        diff     = longint'(ones) - expected;
        tol      = longint'(cycles) * 3 / 100;
        if (diff < 0)
            diff = -diff;
        assert (diff <= tol)
            else report_and_stop($sformatf("MISMATCH t=%0t %s ones=%0d expected=%0d of %0d",
                                           $time, name, ones, expected, cycles));
    endtask

    task automatic wait_underrun(input int limit, input logic expect_idle,
                                 input string where_txt);
        int n;
        n = 0;
        @(negedge clk);
        while (!underrun) begin
            if (expect_idle) begin
                expect_low(dac_out_l, "dac_out_l");
                expect_low(dac_out_r, "dac_out_r");
            end
            assert (n < limit)
                else report_and_stop($sformatf("Timeout: no underrun pulse %s within %0d cycles",
                                               where_txt, limit));
            n++;
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------
    // One table row
    // ------------------------------------------------------------

    task automatic run_row(input int idx);
        stereo_sample_t value;
        int             ones_l;
        int             ones_r;
        int             pulses;
        int             cycles;
        value.left  = SAMPLE_W'(ROW_LEFT[idx]);
        value.right = SAMPLE_W'(ROW_RIGHT[idx]);
        ones_l = 0;
        ones_r = 0;
        pulses = 0;
        cycles = 0;
        for (int s = 0; s < ROW_STROBES[idx]; s++) begin
            for (int c = 0; c < IN_PERIOD; c++) begin
                @(posedge clk);
                sample_in_rdy <= (c == 0);
                sample_in     <= value;
                @(negedge clk);
                if (s >= SETTLE) begin
                    if (dac_out_l)
                        ones_l++;
                    if (dac_out_r)
                        ones_r++;
                    if (underrun)
                        pulses++;
                    cycles++;
                end
            end
        end
        assert (pulses == 0)
            else report_and_stop($sformatf("MISMATCH t=%0t underrun pulses=%0d expected=0",
                                           $time, pulses));
        check_density("dac_out_l", ones_l, cycles, ROW_LEFT[idx]);
        check_density("dac_out_r", ones_r, cycles, ROW_RIGHT[idx]);
        $display("row %0d: left %0d ones %0d, right %0d ones %0d, %0d cycles",
                 idx, ROW_LEFT[idx], ones_l, ROW_RIGHT[idx], ones_r, cycles);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in     = '0;

        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            @(negedge clk);
            expect_low(dac_out_l, "dac_out_l");
            expect_low(dac_out_r, "dac_out_r");
            expect_low(underrun, "underrun");
        end
        @(posedge clk);
        reset <= 1'b0;

        // Timer runs with an empty output FIFO
        wait_underrun(IDLE_WAIT, 1'b1, "before any input");

        for (int r = 0; r < N_ROWS; r++)
            run_row(r);

        // Input stops and the output FIFO drains
        wait_underrun(DRAIN_WAIT, 1'b0, "after input stopped");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
dac_pkg.sv
sample_fifo.sv
interp_2x.sv
dac_sequencer.sv
rate_timer.sv
sigma_delta_mod.sv
stereo_dac_output.sv
tb_stereo_dac_output.sv

// ==== Makefile ====
TOP  := tb_stereo_dac_output
SRCS := $(shell cat all.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

obj_dir/V$(TOP): all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

clean:
	rm -rf obj_dir
